//--- src.f
common/bridge_pkg.sv
axil_slave/axil_write_channel.sv
axil_slave/axil_read_channel.sv
verilog/ipif_ctrl.sv
verilog/axil_ipif_bridge.sv
verif/ipif_reg_model.sv
verif/tb_bridge.sv

//--- Makefile
# Verilator build for the AXI4-Lite to IPIF bridge
# override any variable on the command line, e.g. make sim SEED=5

VERILATOR ?= verilator
TOP       ?= tb_bridge
SEED      ?= 22
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

# lint the whole project, testbench included
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# build and run; the exit status is nonzero when the testbench stops with $$fatal
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- verif/tb_bridge.sv
`timescale 1ns/1ps

module tb_bridge #(
  parameter int SEED = 22
);

  localparam int ADDR_W     = bridge_pkg::ADDR_W;
  localparam int DATA_W     = bridge_pkg::DATA_W;
  localparam int STRB_W     = bridge_pkg::STRB_W;
  // cycles any single wait may take
  localparam int WAIT_LIMIT = 200;

  logic                  s_axi_aclk;
  logic                  s_axi_aresetn;
  logic [ADDR_W-1:0]     s_axi_awaddr;
  logic                  s_axi_awvalid;
  logic                  s_axi_awready;
  logic [DATA_W-1:0]     s_axi_wdata;
  logic [STRB_W-1:0]     s_axi_wstrb;
  logic                  s_axi_wvalid;
  logic                  s_axi_wready;
  bridge_pkg::axi_resp_e s_axi_bresp;
  logic                  s_axi_bvalid;
  logic                  s_axi_bready;
  logic [ADDR_W-1:0]     s_axi_araddr;
  logic                  s_axi_arvalid;
  logic                  s_axi_arready;
  logic [DATA_W-1:0]     s_axi_rdata;
  bridge_pkg::axi_resp_e s_axi_rresp;
  logic                  s_axi_rvalid;
  logic                  s_axi_rready;
  bridge_pkg::ipif_req_t ipif_req;
  bridge_pkg::ipif_rsp_t ipif_rsp;

  // expected register contents
  logic [DATA_W-1:0] shadow [16];

  axil_ipif_bridge #(
    .ACK_TIMEOUT (16)
  ) dut0 (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .ipif_req      (ipif_req),
    .ipif_rsp      (ipif_rsp)
  );

  ipif_reg_model #(
    .SEED (SEED)
  ) u_model (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .ipif_req      (ipif_req),
    .ipif_rsp      (ipif_rsp)
  );

  // 40 ns period
  initial
    s_axi_aclk = 1'b0;
  always #20 s_axi_aclk = ~s_axi_aclk;

  ////////////////////
  // helpers and compares
  ////////////////////

  // inputs change 2 ns after the edge, outputs are sampled there too
  task automatic next_cycle();
    @(posedge s_axi_aclk);
    #2;
  endtask

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    abort_run();
  endtask

  task automatic check_resp(input string name, input bridge_pkg::axi_resp_e got,
                            input bridge_pkg::axi_resp_e exp);
    if (got !== exp)
    begin
      $display("Fail %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp)
    begin
      $display("Fail %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Fail %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // byte lanes with a set strobe take the new data
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                    input logic [DATA_W-1:0] data,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] merged;
    merged = old;
    for (int b = 0; b < STRB_W; b++)
      if (strb[b])
        merged[8*b +: 8] = data[8*b +: 8];
    return merged;
  endfunction

  ////////////////////
  // axi driver
  ////////////////////

  // aw and w together, dropped after the ready cycle
  task automatic issue_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb);
    int n;
    n = 0;
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    while (!s_axi_awready)
    begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT)
        report_timeout("s_axi_awready");
    end
    check_level("s_axi_wready", s_axi_wready, 1'b1);
    next_cycle();
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
  endtask

  // bready stays low for hold cycles after bvalid, the response must not move
  task automatic collect_bresp(input int hold, output bridge_pkg::axi_resp_e resp);
    int n;
    n = 0;
    while (!s_axi_bvalid)
    begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT)
        report_timeout("s_axi_bvalid");
    end
    resp = s_axi_bresp;
    repeat (hold)
    begin
      next_cycle();
      check_level("s_axi_bvalid", s_axi_bvalid, 1'b1);
      check_resp("s_axi_bresp", s_axi_bresp, resp);
      check_level("s_axi_awready", s_axi_awready, 1'b0);
    end
    s_axi_bready = 1'b1;
    next_cycle();
    s_axi_bready = 1'b0;
  endtask

  task automatic issue_read(input logic [ADDR_W-1:0] addr);
    int n;
    n = 0;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    while (!s_axi_arready)
    begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT)
        report_timeout("s_axi_arready");
    end
    next_cycle();
    s_axi_arvalid = 1'b0;
  endtask

  task automatic collect_rdata(output logic [DATA_W-1:0] data,
                               output bridge_pkg::axi_resp_e resp);
    int n;
    n = 0;
    s_axi_rready = 1'b1;
    while (!s_axi_rvalid)
    begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT)
        report_timeout("s_axi_rvalid");
    end
    data = s_axi_rdata;
    resp = s_axi_rresp;
    next_cycle();
    s_axi_rready = 1'b0;
  endtask

  task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb, input bridge_pkg::axi_resp_e exp);
    bridge_pkg::axi_resp_e resp;
    issue_write(addr, data, strb);
    collect_bresp(0, resp);
    check_resp("s_axi_bresp", resp, exp);
  endtask

  // rdata only compared on okay
  task automatic axi_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp_data,
                          input bridge_pkg::axi_resp_e exp);
    logic [DATA_W-1:0]     data;
    bridge_pkg::axi_resp_e resp;
    issue_read(addr);
    collect_rdata(data, resp);
    check_resp("s_axi_rresp", resp, exp);
    if (exp == bridge_pkg::resp_okay)
      check_data("s_axi_rdata", data, exp_data);
  endtask

  task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb);
    axi_write(addr, data, strb, bridge_pkg::resp_okay);
    shadow[addr[5:2]] = merge_bytes(shadow[addr[5:2]], data, strb);
  endtask

  task automatic read_reg(input logic [ADDR_W-1:0] addr);
    axi_read(addr, shadow[addr[5:2]], bridge_pkg::resp_okay);
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic test_reset();
    check_level("s_axi_awready", s_axi_awready, 1'b0);
    check_level("s_axi_wready", s_axi_wready, 1'b0);
    check_level("s_axi_arready", s_axi_arready, 1'b0);
    check_level("s_axi_bvalid", s_axi_bvalid, 1'b0);
    check_level("s_axi_rvalid", s_axi_rvalid, 1'b0);
    check_level("ipif_req.cs", ipif_req.cs, 1'b0);
    axi_read(32'h0C, 32'h0, bridge_pkg::resp_okay);
  endtask

  task automatic test_merge();
    write_reg(32'h00, 32'h11223344, 4'hF);
    write_reg(32'h00, 32'hAABBCCDD, 4'h5);
    write_reg(32'h14, 32'hDEADBEEF, 4'hC);
    write_reg(32'h3C, 32'h01234567, 4'hF);
    write_reg(32'h3C, 32'hFFFFFFFF, 4'h2);
    write_reg(32'h10, 32'h5A5A5A5A, 4'h8);
    read_reg(32'h00);
    read_reg(32'h14);
    read_reg(32'h3C);
    read_reg(32'h10);
    read_reg(32'h04);
  endtask

  task automatic test_errors();
    axi_write(32'h104, 32'h12345678, 4'hF, bridge_pkg::resp_slverr);
    axi_read(32'h104, 32'h0, bridge_pkg::resp_slverr);
  endtask

  // no answer from the ip, ends on the ack timeout
  task automatic test_timeout();
    axi_read(32'h200, 32'h0, bridge_pkg::resp_slverr);
    axi_write(32'h200, 32'h87654321, 4'hF, bridge_pkg::resp_slverr);
    write_reg(32'h08, 32'hC0FFEE00, 4'hF);
    read_reg(32'h08);
  endtask

  task automatic test_backpressure();
    bridge_pkg::axi_resp_e resp_a;
    bridge_pkg::axi_resp_e resp_b;
    issue_write(32'h24, 32'hCAFE0001, 4'hF);
    // second write waits while the first response is held
    fork
      issue_write(32'h28, 32'h0BAD0002, 4'h3);
      collect_bresp(8, resp_a);
    join
    check_resp("s_axi_bresp", resp_a, bridge_pkg::resp_okay);
    collect_bresp(0, resp_b);
    check_resp("s_axi_bresp", resp_b, bridge_pkg::resp_okay);
    shadow[9]  = merge_bytes(shadow[9], 32'hCAFE0001, 4'hF);
    shadow[10] = merge_bytes(shadow[10], 32'h0BAD0002, 4'h3);
    read_reg(32'h24);
    read_reg(32'h28);
  endtask

  task automatic test_same_cycle();
    logic [DATA_W-1:0] new_val;
    // different registers, the read sees the old contents
    fork
      write_reg(32'h18, 32'h76543210, 4'hF);
      axi_read(32'h1C, shadow[7], bridge_pkg::resp_okay);
    join
    read_reg(32'h18);
    // same register, write goes first so the read sees the new value
    new_val = merge_bytes(shadow[5], 32'h99887766, 4'h3);
    fork
      axi_write(32'h14, 32'h99887766, 4'h3, bridge_pkg::resp_okay);
      axi_read(32'h14, new_val, bridge_pkg::resp_okay);
    join
    shadow[5] = new_val;
  endtask

  initial
  begin
    s_axi_aresetn = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    for (int i = 0; i < 16; i++)
      shadow[i] = '0;
    repeat (10) @(posedge s_axi_aclk);
    #2;
    s_axi_aresetn = 1'b1;
    test_reset();
    test_merge();
    test_errors();
    test_timeout();
    test_backpressure();
    test_same_cycle();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- verif/ipif_reg_model.sv
`timescale 1ns/1ps

module ipif_reg_model #(
  parameter int SEED = 22
) (
  input  logic                  s_axi_aclk,
  input  logic                  s_axi_aresetn,
  input  bridge_pkg::ipif_req_t ipif_req,
  output bridge_pkg::ipif_rsp_t ipif_rsp
);

  // 16 words, indexed by addr[5:2]
  logic [bridge_pkg::DATA_W-1:0] regs [16];

  // one access per cs period
  logic       busy;
  logic       answered;
  logic [1:0] delay;
  logic [3:0] idx;
  // 0x100..0x1ff answer with an error, 0x200 and up stay silent
  logic       err_range;
  logic       dead_range;

  assign idx        = ipif_req.addr[5:2];
  assign err_range  = (ipif_req.addr >= 32'h100) && (ipif_req.addr < 32'h200);
  assign dead_range = (ipif_req.addr >= 32'h200);

  // seeded once for the whole run
  initial
  begin
    void'($urandom(SEED));
  end

  always_ff @(posedge s_axi_aclk)
  begin
    if (!s_axi_aresetn)
    begin
      busy     <= 1'b0;
      answered <= 1'b0;
      delay    <= '0;
      ipif_rsp <= '0;
      for (int i = 0; i < 16; i++)
        regs[i] <= '0;
    end
    else
    begin
      // ack and error are single cycle pulses
      ipif_rsp.wr_ack   <= 1'b0;
      ipif_rsp.rd_ack   <= 1'b0;
      ipif_rsp.wr_error <= 1'b0;
      ipif_rsp.rd_error <= 1'b0;
      // cs drops for at least one cycle between accesses
      if (!ipif_req.cs)
        busy <= 1'b0;
      else if (!busy)
      begin
        busy     <= 1'b1;
        answered <= 1'b0;
        delay    <= 2'($urandom_range(3, 0));
      end
      else if (delay != 2'd0)
        delay <= delay - 2'd1;
      else if (!answered && !dead_range)
      begin
        answered <= 1'b1;
        if (err_range)
        begin
          ipif_rsp.rd_error <= ipif_req.rnw;
          ipif_rsp.wr_error <= !ipif_req.rnw;
        end
        else if (ipif_req.rnw)
        begin
          ipif_rsp.rd_ack <= 1'b1;
          ipif_rsp.data   <= regs[idx];
        end
        else
        begin
          ipif_rsp.wr_ack <= 1'b1;
          // byte lane merge
          for (int b = 0; b < bridge_pkg::STRB_W; b++)
            if (ipif_req.be[b])
              regs[idx][8*b +: 8] <= ipif_req.data[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- verilog/axil_ipif_bridge.sv
`timescale 1ns/1ps

module axil_ipif_bridge #(
  parameter int ACK_TIMEOUT = 64
) (
  input  logic                          s_axi_aclk,
  input  logic                          s_axi_aresetn,
  // write address and data
  input  logic [bridge_pkg::ADDR_W-1:0] s_axi_awaddr,
  input  logic                          s_axi_awvalid,
  output logic                          s_axi_awready,
  input  logic [bridge_pkg::DATA_W-1:0] s_axi_wdata,
  input  logic [bridge_pkg::STRB_W-1:0] s_axi_wstrb,
  input  logic                          s_axi_wvalid,
  output logic                          s_axi_wready,
  // write response
  output bridge_pkg::axi_resp_e         s_axi_bresp,
  output logic                          s_axi_bvalid,
  input  logic                          s_axi_bready,
  // read address and data
  input  logic [bridge_pkg::ADDR_W-1:0] s_axi_araddr,
  input  logic                          s_axi_arvalid,
  output logic                          s_axi_arready,
  output logic [bridge_pkg::DATA_W-1:0] s_axi_rdata,
  output bridge_pkg::axi_resp_e         s_axi_rresp,
  output logic                          s_axi_rvalid,
  input  logic                          s_axi_rready,
  // ipif side
  output bridge_pkg::ipif_req_t         ipif_req,
  input  bridge_pkg::ipif_rsp_t         ipif_rsp
);

  // requests toward the controller, completion back
  bridge_pkg::wr_req_t    wr_req;
  bridge_pkg::rd_req_t    rd_req;
  bridge_pkg::ctrl_done_t done;

  axil_write_channel u_wr (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .awaddr        (s_axi_awaddr),
    .awvalid       (s_axi_awvalid),
    .wdata         (s_axi_wdata),
    .wstrb         (s_axi_wstrb),
    .wvalid        (s_axi_wvalid),
    .bready        (s_axi_bready),
    .done          (done),
    .awready       (s_axi_awready),
    .wready        (s_axi_wready),
    .bresp         (s_axi_bresp),
    .bvalid        (s_axi_bvalid),
    .wr_req        (wr_req)
  );

  axil_read_channel u_rd (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .araddr        (s_axi_araddr),
    .arvalid       (s_axi_arvalid),
    .rready        (s_axi_rready),
    .done          (done),
    .arready       (s_axi_arready),
    .rdata         (s_axi_rdata),
    .rresp         (s_axi_rresp),
    .rvalid        (s_axi_rvalid),
    .rd_req        (rd_req)
  );

  // write wins when both channels hold a request
  ipif_ctrl #(
    .ACK_TIMEOUT (ACK_TIMEOUT)
  ) u_ctrl (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .wr_req        (wr_req),
    .rd_req        (rd_req),
    .ipif_rsp      (ipif_rsp),
    .ipif_req      (ipif_req),
    .done          (done)
  );

endmodule

//--- verilog/ipif_ctrl.sv
`timescale 1ns/1ps

module ipif_ctrl #(
  parameter int ACK_TIMEOUT = 64
) (
  input  logic                   s_axi_aclk,
  input  logic                   s_axi_aresetn,
  input  bridge_pkg::wr_req_t    wr_req,
  input  bridge_pkg::rd_req_t    rd_req,
  input  bridge_pkg::ipif_rsp_t  ipif_rsp,
  output bridge_pkg::ipif_req_t  ipif_req,
  output bridge_pkg::ctrl_done_t done
);

  // wide enough to hold ACK_TIMEOUT
  localparam int CNT_W = $clog2(ACK_TIMEOUT + 1);

  bridge_pkg::ctrl_state_e state;
  bridge_pkg::ctrl_state_e state_nxt;

  logic [CNT_W-1:0]              ack_cnt;
  logic                          timeout;
  logic                          access_end;
  logic                          access_err;
  logic                          done_wr;
  logic                          done_rd;
  logic                          done_err;
  logic [bridge_pkg::DATA_W-1:0] done_rdata;

  // last allowed cycle of an access
  assign timeout = (ack_cnt == CNT_W'(ACK_TIMEOUT - 1));

  ////////////////////
  // arbitration and end of access
  ////////////////////

  always_comb
  begin
    state_nxt  = state;
    access_end = 1'b0;
    access_err = 1'b0;
    unique case (state)
      bridge_pkg::st_idle:
      begin
        // the request is still up during its own done pulse so it is skipped then
        if (wr_req.valid && !done_wr)
          state_nxt = bridge_pkg::st_write;
        else if (rd_req.valid && !done_rd)
          state_nxt = bridge_pkg::st_read;
      end
      bridge_pkg::st_write:
      begin
        access_end = ipif_rsp.wr_ack || ipif_rsp.wr_error || timeout;
        access_err = ipif_rsp.wr_error || (timeout && !ipif_rsp.wr_ack);
      end
      bridge_pkg::st_read:
      begin
        access_end = ipif_rsp.rd_ack || ipif_rsp.rd_error || timeout;
        access_err = ipif_rsp.rd_error || (timeout && !ipif_rsp.rd_ack);
      end
      default: state_nxt = bridge_pkg::st_idle;
    endcase
    if (access_end)
      state_nxt = bridge_pkg::st_idle;
  end

  always_ff @(posedge s_axi_aclk)
  begin
    if (!s_axi_aresetn)
    begin
      state    <= bridge_pkg::st_idle;
      ack_cnt  <= '0;
      done_wr  <= 1'b0;
      done_rd  <= 1'b0;
      done_err <= 1'b0;
    end
    else
    begin
      state    <= state_nxt;
      done_wr  <= (state == bridge_pkg::st_write) && access_end;
      done_rd  <= (state == bridge_pkg::st_read) && access_end;
      done_err <= access_end && access_err;
      // count cycles of the current access only
      if (state == bridge_pkg::st_idle || access_end)
        ack_cnt <= '0;
      else
        ack_cnt <= ack_cnt + 1'b1;
    end
  end

  always_ff @(posedge s_axi_aclk)
  begin
    if (state == bridge_pkg::st_read && access_end)
      done_rdata <= ipif_rsp.data;
  end

  assign done = '{wr_done: done_wr, rd_done: done_rd, err: done_err, rdata: done_rdata};

  ////////////////////
  // ipif drive from the granted request
  ////////////////////

  assign ipif_req.cs   = (state != bridge_pkg::st_idle);
  assign ipif_req.rnw  = (state == bridge_pkg::st_read);
  assign ipif_req.addr = (state == bridge_pkg::st_write) ? wr_req.addr : rd_req.addr;
  // data is zero outside writes and all lanes are enabled on reads
  assign ipif_req.data = (state == bridge_pkg::st_write) ? wr_req.data : '0;
  assign ipif_req.be   = (state == bridge_pkg::st_write) ? wr_req.strb : '1;

  // every access ends with a done pulse
  a_cs_fall_done: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    $fell(ipif_req.cs) |-> done.wr_done || done.rd_done)
    else $error("cs dropped without a done pulse");

  // done only answers a request that is still pending in its channel
  a_done_after_access: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    done.wr_done || done.rd_done |-> (done.wr_done ? wr_req.valid : rd_req.valid))
    else $error("done pulsed with no pending request");

endmodule

//--- axil_slave/axil_read_channel.sv
`timescale 1ns/1ps

module axil_read_channel (
  input  logic                          s_axi_aclk,
  input  logic                          s_axi_aresetn,
  input  logic [bridge_pkg::ADDR_W-1:0] araddr,
  input  logic                          arvalid,
  input  logic                          rready,
  input  bridge_pkg::ctrl_done_t        done,
  output logic                          arready,
  output logic [bridge_pkg::DATA_W-1:0] rdata,
  output bridge_pkg::axi_resp_e         rresp,
  output logic                          rvalid,
  output bridge_pkg::rd_req_t           rd_req
);

  // pending read
  logic                          req_valid;
  logic [bridge_pkg::ADDR_W-1:0] req_addr;

  // one read in the channel at a time as request or response
  logic accept;
  logic taken;

  assign accept = arvalid && !arready && !req_valid && !rvalid;
  assign taken  = arready && arvalid;

  ////////////////////
  // ready pulse, request and response
  ////////////////////

  always_ff @(posedge s_axi_aclk)
  begin
    if (!s_axi_aresetn)
    begin
      arready   <= 1'b0;
      req_valid <= 1'b0;
      rvalid    <= 1'b0;
      rresp     <= bridge_pkg::resp_okay;
    end
    else
    begin
      arready <= accept;
      if (taken)
        req_valid <= 1'b1;
      else if (done.rd_done)
        req_valid <= 1'b0;
      // rvalid rises the cycle after rd_done
      if (done.rd_done)
      begin
        rvalid <= 1'b1;
        rresp  <= done.err ? bridge_pkg::resp_slverr : bridge_pkg::resp_okay;
      end
      else if (rvalid && rready)
        rvalid <= 1'b0;
    end
  end

  // address and read data
  always_ff @(posedge s_axi_aclk)
  begin
    if (taken)
      req_addr <= araddr;
    // data is don't care on slverr
    if (done.rd_done)
      rdata <= done.rdata;
  end

  assign rd_req = '{valid: req_valid, addr: req_addr};

  // data and response must sit still until rready
  a_rvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("read response changed before rready");

endmodule

//--- axil_slave/axil_write_channel.sv
`timescale 1ns/1ps

module axil_write_channel (
  input  logic                                s_axi_aclk,
  input  logic                                s_axi_aresetn,
  input  logic [bridge_pkg::ADDR_W-1:0]       awaddr,
  input  logic                                awvalid,
  input  logic [bridge_pkg::DATA_W-1:0]       wdata,
  input  logic [bridge_pkg::STRB_W-1:0]       wstrb,
  input  logic                                wvalid,
  input  logic                                bready,
  input  bridge_pkg::ctrl_done_t              done,
  output logic                                awready,
  output logic                                wready,
  output bridge_pkg::axi_resp_e               bresp,
  output logic                                bvalid,
  output bridge_pkg::wr_req_t                 wr_req
);

  // pending write, valid is control and the rest is payload
  logic                          req_valid;
  logic [bridge_pkg::ADDR_W-1:0] req_addr;
  logic [bridge_pkg::DATA_W-1:0] req_data;
  logic [bridge_pkg::STRB_W-1:0] req_strb;

  // address and data are only taken as a pair, and only with nothing outstanding
  logic accept;
  // handshake cycle on both channels
  logic taken;

  assign accept = awvalid && wvalid && !awready && !req_valid && !bvalid;
  assign taken  = awready && awvalid && wready && wvalid;

  ////////////////////
  // ready pulses and request level
  ////////////////////

  always_ff @(posedge s_axi_aclk)
  begin
    if (!s_axi_aresetn)
    begin
      awready   <= 1'b0;
      wready    <= 1'b0;
      req_valid <= 1'b0;
      bvalid    <= 1'b0;
      bresp     <= bridge_pkg::resp_okay;
    end
    else
    begin
      // single cycle pulse, the !awready term keeps it from repeating
      awready <= accept;
      wready  <= accept;
      if (taken)
        req_valid <= 1'b1;
      else if (done.wr_done)
        req_valid <= 1'b0;
      // response waits here until the master takes it
      if (done.wr_done)
      begin
        bvalid <= 1'b1;
        bresp  <= done.err ? bridge_pkg::resp_slverr : bridge_pkg::resp_okay;
      end
      else if (bvalid && bready)
        bvalid <= 1'b0;
    end
  end

  // strobes travel with the data, no extra delay
  always_ff @(posedge s_axi_aclk)
  begin
    if (taken)
    begin
      req_addr <= awaddr;
      req_data <= wdata;
      req_strb <= wstrb;
    end
  end

  assign wr_req = '{valid: req_valid, addr: req_addr, data: req_data, strb: req_strb};

  ////////////////////
  // checks
  ////////////////////

  // response must not change or drop before bready
  a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("bvalid or bresp changed before bready");

  // controller reads the request fields over several cycles
  a_wr_req_stable: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    wr_req.valid |=> !wr_req.valid || $stable(wr_req))
    else $error("write request changed while valid");

endmodule

//--- common/bridge_pkg.sv
package bridge_pkg;

  ////////////////////
  // bus widths
  ////////////////////

  // address and data are fixed at 32 bits
  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;
  // one strobe per byte lane
  parameter int STRB_W = DATA_W / 8;

  // axi response codes, only okay and slverr are produced
  typedef enum logic [1:0] {
    resp_okay   = 2'd0,
    resp_slverr = 2'd2
  } axi_resp_e;

  // controller states, one ipif access at a time
  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_read
  } ctrl_state_e;

  ////////////////////
  // request and completion records
  ////////////////////

  // pending write from the write channel
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } wr_req_t;

  // pending read from the read channel
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } rd_req_t;

  // completion back to both channels, err and rdata qualify the pulses
  typedef struct packed {
    logic              wr_done;
    logic              rd_done;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } ctrl_done_t;

  // bus to ip side
  typedef struct packed {
    logic              cs;
    logic              rnw;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] be;
  } ipif_req_t;

  // ip to bus side
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              wr_ack;
    logic              rd_ack;
    logic              wr_error;
    logic              rd_error;
  } ipif_rsp_t;

endpackage
